/* hdl/rv_core_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// rv64i core shared types
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rv_core_pkg;

  //////////////////////////////////////////////////////////////////////////
  // widths

  // integer register width
  localparam int XLEN   = 64;
  // instruction word width
  localparam int INST_W = 32;
  // register index width, x0..x31
  localparam int REG_AW = 5;
  // bus response width
  localparam int RESP_W = 2;

  //////////////////////////////////////////////////////////////////////////
  // enums

  // operation carried from decode to execute
  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_LUI = 4'd6,
    OP_BEQ = 4'd7,
    OP_BNE = 4'd8,
    OP_JAL = 4'd9
  } alu_op_e;

  // fetch sequencing
  typedef enum logic [1:0] {
    FS_REQ  = 2'd0,  // bus request out
    FS_HOLD = 2'd1,  // fetched level up, wait for decode ack
    FS_WAIT = 2'd2   // wait for commit of this instruction
  } fetch_state_e;

  //////////////////////////////////////////////////////////////////////////
  // stage packets

  // fetch to decode
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
    logic              nocmt;
  } fetch_pkt_t;

  // decode to execute
  // rs2_val already holds the immediate for ADDI
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    alu_op_e           op;
    logic [REG_AW-1:0] rd;
    logic              wen;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   imm;
    logic              nocmt;
  } dec_pkt_t;

  // execute to writeback
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              wen;
    logic [XLEN-1:0]   data;
    logic              jmp;
    logic [XLEN-1:0]   jmpaddr;
    logic              nocmt;
  } exe_res_t;

endpackage

`default_nettype wire

/* hdl/if_stage.sv */
////////////////////////////////////////////////////////////////////////////
// instruction fetch stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                              clk,
  input  wire                              i_rst_n,

  // instruction bus
  input  wire                              i_if_axi_ready,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_if_axi_data_read,
  input  wire  [rv_core_pkg::RESP_W-1:0]   i_if_axi_resp,
  output logic                             o_if_axi_valid,
  output logic [rv_core_pkg::XLEN-1:0]     o_if_axi_addr,

  // fetched handshake with decode
  input  wire                              i_if_fetched_ack,
  output logic                             o_if_fetched_req,
  output rv_core_pkg::fetch_pkt_t          o_if_fetch,

  // redirect from writeback
  input  wire                              i_cmt_valid,
  input  wire                              i_if_pc_jmp,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_if_pc_jmpaddr
);

  import rv_core_pkg::*;

  fetch_state_e      state;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   pc_next;
  logic [INST_W-1:0] inst_sel;
  logic              bus_err;

  //////////////////////////////////////////////////////////////////////////
  // bus side

  // bus works on 64-bit words
  assign o_if_axi_addr = {pc[XLEN-1:3], 3'b000};

  // upper or lower half by pc bit 2
  assign inst_sel = pc[2] ? i_if_axi_data_read[2*INST_W-1:INST_W]
                          : i_if_axi_data_read[INST_W-1:0];

  // any nonzero response kills the instruction
  assign bus_err = |i_if_axi_resp;

  // taken redirect or sequential
  assign pc_next = i_if_pc_jmp ? i_if_pc_jmpaddr : pc + XLEN'(4);

  //////////////////////////////////////////////////////////////////////////
  // fetch FSM

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state            <= FS_REQ;
      pc               <= RESET_PC;
      o_if_axi_valid   <= 1'b0;
      o_if_fetched_req <= 1'b0;
      o_if_fetch       <= '0;
    end else begin
      case (state)
        FS_REQ: begin
          // first request after reset
          if (!o_if_axi_valid) begin
            o_if_axi_valid <= 1'b1;
          end else if (i_if_axi_ready) begin
            // word arrives, hand it to decode
            o_if_axi_valid   <= 1'b0;
            o_if_fetched_req <= 1'b1;
            o_if_fetch.pc    <= pc;
            o_if_fetch.inst  <= inst_sel;
            o_if_fetch.nocmt <= bus_err;
            state            <= FS_HOLD;
          end
        end
        FS_HOLD: begin
          // level drops once decode has taken it
          if (i_if_fetched_ack) begin
            o_if_fetched_req <= 1'b0;
            state            <= FS_WAIT;
          end
        end
        FS_WAIT: begin
          // one in flight, restart on commit
          if (i_cmt_valid) begin
            pc             <= pc_next;
            o_if_axi_valid <= 1'b1;
            state          <= FS_REQ;
          end
        end
        default: begin
          state <= FS_REQ;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
////////////////////////////////////////////////////////////////////////////
// instruction decode stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire                              clk,
  input  wire                              i_rst_n,

  // from fetch
  input  wire                              i_fetched_req,
  input  wire  rv_core_pkg::fetch_pkt_t    i_fetch,
  output logic                             o_fetched_ack,

  // register file read
  output logic [rv_core_pkg::REG_AW-1:0]   o_rs1_addr,
  output logic [rv_core_pkg::REG_AW-1:0]   o_rs2_addr,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_rs1_val,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_rs2_val,

  // to execute
  output logic                             o_dec_valid,
  output rv_core_pkg::dec_pkt_t            o_dec
);

  import rv_core_pkg::*;

  // major opcodes used here
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [INST_W-1:0] inst;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   imm_b;
  logic [XLEN-1:0]   imm_j;
  alu_op_e           op;
  logic              writes;
  logic              use_imm;
  logic [XLEN-1:0]   imm;
  dec_pkt_t          dec_next;

  //////////////////////////////////////////////////////////////////////////
  // fields and immediates

  assign inst   = i_fetch.inst;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // sign extended from bit 31 in every format
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // read ports straight from the raw word
  assign o_rs1_addr = inst[19:15];
  assign o_rs2_addr = inst[24:20];

  // take the request in the cycle it shows up
  assign o_fetched_ack = i_fetched_req;

  //////////////////////////////////////////////////////////////////////////
  // opcode decode

  always_comb begin
    op      = OP_NOP;
    writes  = 1'b0;
    use_imm = 1'b0;
    imm     = '0;
    // bus error leaves a plain NOP
    if (!i_fetch.nocmt) begin
      case (opcode)
        OPC_OPIMM: begin
          if (funct3 == 3'b000) begin
            op      = OP_ADD;
            writes  = 1'b1;
            use_imm = 1'b1;
            imm     = imm_i;
          end
        end
        OPC_OP: begin
          writes = 1'b1;
          case ({funct7, funct3})
            {7'b0000000, 3'b000}: op = OP_ADD;
            {7'b0100000, 3'b000}: op = OP_SUB;
            {7'b0000000, 3'b111}: op = OP_AND;
            {7'b0000000, 3'b110}: op = OP_OR;
            {7'b0000000, 3'b100}: op = OP_XOR;
            default:              writes = 1'b0;
          endcase
        end
        OPC_LUI: begin
          op     = OP_LUI;
          writes = 1'b1;
          imm    = imm_u;
        end
        OPC_BRANCH: begin
          imm = imm_b;
          if (funct3 == 3'b000) begin
            op = OP_BEQ;
          end else if (funct3 == 3'b001) begin
            op = OP_BNE;
          end
        end
        OPC_JAL: begin
          op     = OP_JAL;
          writes = 1'b1;
          imm    = imm_j;
        end
        default: begin
          op = OP_NOP;
        end
      endcase
    end
  end

  // packet assembly, x0 target never writes
  always_comb begin
    dec_next         = '0;
    dec_next.pc      = i_fetch.pc;
    dec_next.op      = op;
    dec_next.rd      = writes ? rd : '0;
    dec_next.wen     = writes && (rd != '0);
    dec_next.rs1_val = i_rs1_val;
    dec_next.rs2_val = use_imm ? imm : i_rs2_val;
    dec_next.imm     = imm;
    dec_next.nocmt   = i_fetch.nocmt;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec_valid <= 1'b0;
      o_dec       <= '0;
    end else begin
      o_dec_valid <= o_fetched_ack;
      // operands sampled together with the ack
      if (o_fetched_ack) begin
        o_dec <= dec_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/exe_stage.sv */
////////////////////////////////////////////////////////////////////////////
// execute stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_stage (
  input  wire                            clk,
  input  wire                            i_rst_n,

  // from decode
  input  wire                            i_dec_valid,
  input  wire  rv_core_pkg::dec_pkt_t    i_dec,

  // to writeback
  output logic                           o_exe_valid,
  output rv_core_pkg::exe_res_t          o_exe
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] alu_out;
  logic            taken;
  exe_res_t        res_next;

  //////////////////////////////////////////////////////////////////////////
  // operands and addresses

  assign opa = i_dec.rs1_val;
  // holds imm for ADDI
  assign opb = i_dec.rs2_val;

  // return address for JAL
  assign link = i_dec.pc + XLEN'(4);

  // branch and jump share one adder
  assign target = i_dec.pc + i_dec.imm;

  //////////////////////////////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (i_dec.op)
      OP_ADD:  alu_out = opa + opb;
      OP_SUB:  alu_out = opa - opb;
      OP_AND:  alu_out = opa & opb;
      OP_OR:   alu_out = opa | opb;
      OP_XOR:  alu_out = opa ^ opb;
      OP_LUI:  alu_out = i_dec.imm;
      OP_JAL:  alu_out = link;
      default: alu_out = '0;
    endcase
  end

  // branch compare
  always_comb begin
    case (i_dec.op)
      OP_BEQ:  taken = (opa == opb);
      OP_BNE:  taken = (opa != opb);
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res_next         = '0;
    res_next.pc      = i_dec.pc;
    res_next.rd      = i_dec.rd;
    res_next.wen     = i_dec.wen;
    res_next.data    = alu_out;
    res_next.jmp     = taken;
    res_next.jmpaddr = target;
    res_next.nocmt   = i_dec.nocmt;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_exe_valid <= 1'b0;
      o_exe       <= '0;
    end else begin
      o_exe_valid <= i_dec_valid;
      if (i_dec_valid) begin
        o_exe <= res_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/wb_stage.sv */
////////////////////////////////////////////////////////////////////////////
// writeback and register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  wire                              clk,
  input  wire                              i_rst_n,

  // from execute
  input  wire                              i_exe_valid,
  input  wire  rv_core_pkg::exe_res_t      i_exe,

  // read ports for decode
  input  wire  [rv_core_pkg::REG_AW-1:0]   i_rs1_addr,
  input  wire  [rv_core_pkg::REG_AW-1:0]   i_rs2_addr,
  output logic [rv_core_pkg::XLEN-1:0]     o_rs1_val,
  output logic [rv_core_pkg::XLEN-1:0]     o_rs2_val,

  // commit report
  output logic                             o_cmt_valid,
  output logic [rv_core_pkg::XLEN-1:0]     o_cmt_pc,
  output logic [rv_core_pkg::REG_AW-1:0]   o_cmt_rd,
  output logic                             o_cmt_wen,
  output logic [rv_core_pkg::XLEN-1:0]     o_cmt_data,
  output logic                             o_cmt_nocmt,

  // redirect to fetch
  output logic                             o_pc_jmp,
  output logic [rv_core_pkg::XLEN-1:0]     o_pc_jmpaddr
);

  import rv_core_pkg::*;

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];
  logic            wr_en;

  assign wr_en = i_exe_valid && i_exe.wen && (i_exe.rd != '0);

  // x0 reads back zero
  assign o_rs1_val = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_val = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_exe.rd] <= i_exe.data;
    end
  end

  // commit and redirect leave on the same edge as the write
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmt_valid  <= 1'b0;
      o_cmt_pc     <= '0;
      o_cmt_rd     <= '0;
      o_cmt_wen    <= 1'b0;
      o_cmt_data   <= '0;
      o_cmt_nocmt  <= 1'b0;
      o_pc_jmp     <= 1'b0;
      o_pc_jmpaddr <= '0;
    end else begin
      o_cmt_valid <= i_exe_valid;
      if (i_exe_valid) begin
        o_cmt_pc     <= i_exe.pc;
        o_cmt_rd     <= i_exe.rd;
        o_cmt_wen    <= i_exe.wen;
        o_cmt_data   <= i_exe.data;
        o_cmt_nocmt  <= i_exe.nocmt;
        o_pc_jmp     <= i_exe.jmp;
        o_pc_jmpaddr <= i_exe.jmpaddr;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
////////////////////////////////////////////////////////////////////////////
// rv64i subset core top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                              clk,
  input  wire                              i_rst_n,

  // instruction bus
  input  wire                              i_if_axi_ready,
  input  wire  [rv_core_pkg::XLEN-1:0]     i_if_axi_data_read,
  input  wire  [rv_core_pkg::RESP_W-1:0]   i_if_axi_resp,
  output wire                              o_if_axi_valid,
  output wire  [rv_core_pkg::XLEN-1:0]     o_if_axi_addr,

  // commit report
  output wire                              o_cmt_valid,
  output wire  [rv_core_pkg::XLEN-1:0]     o_cmt_pc,
  output wire  [rv_core_pkg::REG_AW-1:0]   o_cmt_rd,
  output wire                              o_cmt_wen,
  output wire  [rv_core_pkg::XLEN-1:0]     o_cmt_data,
  output wire                              o_cmt_nocmt
);

  import rv_core_pkg::*;

  // fetch to decode
  logic              fetched_req;
  logic              fetched_ack;
  fetch_pkt_t        fetch;

  // register reads
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;

  // stage packets
  logic              dec_valid;
  dec_pkt_t          dec;
  logic              exe_valid;
  exe_res_t          exe;

  // redirect back to fetch
  logic              pc_jmp;
  logic [XLEN-1:0]   pc_jmpaddr;

  if_stage #(
    .RESET_PC (RESET_PC)
  ) if_stage_inst (
    .clk                (clk),
    .i_rst_n            (i_rst_n),
    .i_if_axi_ready     (i_if_axi_ready),
    .i_if_axi_data_read (i_if_axi_data_read),
    .i_if_axi_resp      (i_if_axi_resp),
    .o_if_axi_valid     (o_if_axi_valid),
    .o_if_axi_addr      (o_if_axi_addr),
    .i_if_fetched_ack   (fetched_ack),
    .o_if_fetched_req   (fetched_req),
    .o_if_fetch         (fetch),
    .i_cmt_valid        (o_cmt_valid),
    .i_if_pc_jmp        (pc_jmp),
    .i_if_pc_jmpaddr    (pc_jmpaddr)
  );

  id_stage id_stage_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_fetched_req (fetched_req),
    .i_fetch       (fetch),
    .o_fetched_ack (fetched_ack),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .i_rs1_val     (rs1_val),
    .i_rs2_val     (rs2_val),
    .o_dec_valid   (dec_valid),
    .o_dec         (dec)
  );

  exe_stage exe_stage_inst (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_dec_valid (dec_valid),
    .i_dec       (dec),
    .o_exe_valid (exe_valid),
    .o_exe       (exe)
  );

  wb_stage wb_stage_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_exe_valid  (exe_valid),
    .i_exe        (exe),
    .i_rs1_addr   (rs1_addr),
    .i_rs2_addr   (rs2_addr),
    .o_rs1_val    (rs1_val),
    .o_rs2_val    (rs2_val),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt_pc     (o_cmt_pc),
    .o_cmt_rd     (o_cmt_rd),
    .o_cmt_wen    (o_cmt_wen),
    .o_cmt_data   (o_cmt_data),
    .o_cmt_nocmt  (o_cmt_nocmt),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr)
  );

endmodule

`default_nettype wire

/* testbench/tb_rv_core.sv */
////////////////////////////////////////////////////////////////////////////
// rv64i subset core testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  import rv_core_pkg::*;

  localparam logic [XLEN-1:0] BASE = 64'h1000;
  // one past the last program word
  localparam logic [XLEN-1:0] PROG_END = BASE + 64'd256;
  // worst case 3 ready wait + 6 pipeline cycles per instruction
  localparam int TIMEOUT_CYCLES = (64 * (3 + 6) + 4) * 2;

  logic                clk;
  logic                i_rst_n;
  logic                i_if_axi_ready;
  logic [XLEN-1:0]     i_if_axi_data_read;
  logic [RESP_W-1:0]   i_if_axi_resp;
  wire                 o_if_axi_valid;
  wire  [XLEN-1:0]     o_if_axi_addr;
  wire                 o_cmt_valid;
  wire  [XLEN-1:0]     o_cmt_pc;
  wire  [REG_AW-1:0]   o_cmt_rd;
  wire                 o_cmt_wen;
  wire  [XLEN-1:0]     o_cmt_data;
  wire                 o_cmt_nocmt;

  logic [31:0]         prog [0:63];
  logic [XLEN-1:0]     model_regs [0:31];
  logic [XLEN-1:0]     model_pc;
  logic [31:0]         rng;
  logic                run_done;
  logic                first_req;
  int                  commit_cnt;
  int                  cycle_cnt;
  int                  test_checks [0:5];
  int                  test_errs [0:5];

  rv_core_top #(
    .RESET_PC (BASE)
  ) rv_core_top_inst (
    .clk                (clk),
    .i_rst_n            (i_rst_n),
    .i_if_axi_ready     (i_if_axi_ready),
    .i_if_axi_data_read (i_if_axi_data_read),
    .i_if_axi_resp      (i_if_axi_resp),
    .o_if_axi_valid     (o_if_axi_valid),
    .o_if_axi_addr      (o_if_axi_addr),
    .o_cmt_valid        (o_cmt_valid),
    .o_cmt_pc           (o_cmt_pc),
    .o_cmt_rd           (o_cmt_rd),
    .o_cmt_wen          (o_cmt_wen),
    .o_cmt_data         (o_cmt_data),
    .o_cmt_nocmt        (o_cmt_nocmt)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // random source and instruction encoders

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // forward-only control flow, so the run always reaches PROG_END
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] f;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          tgt;
    int          off;
    for (int i = 0; i < 64; i++) begin
      r   = rand32();
      f   = rand32();
      // x0..x7 only, so branches see equal values now and then
      rd  = {2'b00, f[2:0]};
      rs1 = {2'b00, f[5:3]};
      rs2 = {2'b00, f[8:6]};
      tgt = i + 1 + f[10:9];
      if (tgt > 64) begin
        tgt = 64;
      end
      off = 4 * (tgt - i);
      case (r[3:0])
        4'd3:        prog[i] = r_type(7'h00, rs2, rs1, 3'b000, rd);
        4'd4:        prog[i] = r_type(7'h20, rs2, rs1, 3'b000, rd);
        4'd5:        prog[i] = r_type(7'h00, rs2, rs1, 3'b111, rd);
        4'd6:        prog[i] = r_type(7'h00, rs2, rs1, 3'b110, rd);
        4'd7:        prog[i] = r_type(7'h00, rs2, rs1, 3'b100, rd);
        4'd8, 4'd15: prog[i] = u_type(f[31:12], rd);
        4'd9, 4'd10: prog[i] = b_type(off[12:0], rs2, rs1, 3'b000);
        4'd11:       prog[i] = b_type(off[12:0], rs2, rs1, 3'b001);
        4'd12:       prog[i] = j_type(off[20:0], rd);
        4'd13: begin
          // slti, ld and mul are outside the subset
          case (f[31:30])
            2'd0:    prog[i] = 32'h0000_0000;
            2'd1:    prog[i] = i_type(f[20:9], rs1, 3'b010, rd, 7'b0010011);
            2'd2:    prog[i] = i_type(f[20:9], rs1, 3'b011, rd, 7'b0000011);
            default: prog[i] = r_type(7'h01, rs2, rs1, 3'b000, rd);
          endcase
        end
        default:     prog[i] = i_type(f[20:9], rs1, 3'b000, rd, 7'b0010011);
      endcase
    end
  endtask

  // outside the program reads back addi x0, x0, 0
  function automatic logic [31:0] inst_at(input logic [XLEN-1:0] a);
    if (a >= BASE && a < PROG_END) begin
      return prog[(a - BASE) >> 2];
    end
    return 32'h0000_0013;
  endfunction

  // bus words answered with resp 2
  function automatic logic is_err_word(input logic [XLEN-1:0] a);
    case ({a[XLEN-1:3], 3'b000})
      64'h1028, 64'h1060, 64'h10b0: return 1'b1;
      default:                      return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // ISA reference model

  function automatic void ref_step(input  logic [XLEN-1:0] pc,
                                   input  logic [31:0]     inst,
                                   input  logic            err,
                                   output logic [4:0]      rd,
                                   output logic            wen,
                                   output logic [XLEN-1:0] data,
                                   output logic [XLEN-1:0] npc,
                                   output int              cat);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic            writes;
    logic            legal;
    logic            ctrl;
    opc    = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    npc    = pc + 64'd4;
    res    = '0;
    writes = 1'b0;
    legal  = 1'b0;
    ctrl   = 1'b0;
    // a bus error drops the instruction whatever it was
    if (!err) begin
      case (opc)
        7'b0010011: begin
          if (f3 == 3'b000) begin
            legal  = 1'b1;
            writes = 1'b1;
            res    = a + {{52{inst[31]}}, inst[31:20]};
          end
        end
        7'b0110011: begin
          legal  = 1'b1;
          writes = 1'b1;
          if (f7 == 7'h00 && f3 == 3'b000) res = a + b;
          else if (f7 == 7'h20 && f3 == 3'b000) res = a - b;
          else if (f7 == 7'h00 && f3 == 3'b111) res = a & b;
          else if (f7 == 7'h00 && f3 == 3'b110) res = a | b;
          else if (f7 == 7'h00 && f3 == 3'b100) res = a ^ b;
          else begin
            legal  = 1'b0;
            writes = 1'b0;
          end
        end
        7'b0110111: begin
          legal  = 1'b1;
          writes = 1'b1;
          res    = {{32{inst[31]}}, inst[31:12], 12'h000};
        end
        7'b1100011: begin
          if (f3 == 3'b000 || f3 == 3'b001) begin
            legal = 1'b1;
            ctrl  = 1'b1;
            if ((f3 == 3'b000) == (a == b)) begin
              npc = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
          end
        end
        7'b1101111: begin
          legal  = 1'b1;
          writes = 1'b1;
          ctrl   = 1'b1;
          res    = pc + 64'd4;
          npc    = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: begin
          legal = 1'b0;
        end
      endcase
    end
    // x0 is never written
    wen  = writes && (inst[11:7] != 5'd0);
    rd   = wen ? inst[11:7] : 5'd0;
    data = res;
    if (wen) begin
      model_regs[rd] = res;
    end
    if (err || !legal) cat = 5;
    else if (ctrl) cat = 3;
    else if (writes && !wen) cat = 2;
    else cat = 1;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // reporting helpers

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset";
      1:       return "alu_lui";
      2:       return "x0_target";
      3:       return "control_flow";
      4:       return "bus_backpressure";
      default: return "error_illegal";
    endcase
  endfunction

  task automatic report_mismatch(input int t, input string sig, input logic [XLEN-1:0] pc,
                                 input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    test_errs[t]++;
    $display("MISMATCH %0s at pc %h: expected %h actual %h", sig, pc, exp, act);
  endtask

  task automatic note_failure(input int t, input string msg);
    test_errs[t]++;
    $display("error in %0s: %0s", test_name(t), msg);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // memory model, 0..3 wait cycles per request

  initial begin : mem_model
    logic            busy;
    int              wait_left;
    logic [XLEN-1:0] held_addr;
    busy      = 1'b0;
    wait_left = 0;
    held_addr = '0;
    forever begin
      @(posedge clk);
      #2;
      if (i_if_axi_ready) begin
        // word taken at this edge
        i_if_axi_ready     = 1'b0;
        i_if_axi_data_read = '0;
        i_if_axi_resp      = '0;
        busy               = 1'b0;
      end else if (i_rst_n && o_if_axi_valid) begin
        test_checks[4]++;
        if (!busy) begin
          busy      = 1'b1;
          held_addr = o_if_axi_addr;
          wait_left = rand32() % 4;
          if (held_addr[2:0] != 3'b000) begin
            note_failure(4, "bus address not 8-byte aligned");
          end
          if (first_req) begin
            first_req = 1'b0;
            test_checks[0]++;
            if (held_addr !== BASE) begin
              report_mismatch(0, "o_if_axi_addr", BASE, BASE, held_addr);
            end
          end
        end else if (o_if_axi_addr !== held_addr) begin
          report_mismatch(4, "o_if_axi_addr", held_addr, held_addr, o_if_axi_addr);
        end
        if (wait_left == 0) begin
          i_if_axi_ready     = 1'b1;
          i_if_axi_data_read = {inst_at(held_addr + 64'd4), inst_at(held_addr)};
          i_if_axi_resp      = is_err_word(held_addr) ? 2'd2 : 2'd0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // commit checker

  initial begin : commit_check
    logic [XLEN-1:0] pc_now;
    logic [4:0]      e_rd;
    logic            e_wen;
    logic            e_err;
    logic [XLEN-1:0] e_data;
    logic [XLEN-1:0] e_npc;
    int              cat;
    forever begin
      @(posedge clk);
      #1;
      if (o_cmt_valid && run_done) begin
        note_failure(3, "commit after the end of the program");
      end else if (o_cmt_valid) begin
        pc_now = model_pc;
        e_err  = is_err_word(pc_now);
        ref_step(pc_now, inst_at(pc_now), e_err, e_rd, e_wen, e_data, e_npc, cat);
        test_checks[cat]++;
        // pc order follows the model's next pc
        if (o_cmt_pc !== pc_now) begin
          report_mismatch(cat, "o_cmt_pc", pc_now, pc_now, o_cmt_pc);
        end
        if (o_cmt_wen !== e_wen) begin
          report_mismatch(cat, "o_cmt_wen", pc_now, e_wen, o_cmt_wen);
        end
        if (o_cmt_rd !== e_rd) begin
          report_mismatch(cat, "o_cmt_rd", pc_now, e_rd, o_cmt_rd);
        end
        if (o_cmt_nocmt !== e_err) begin
          report_mismatch(cat, "o_cmt_nocmt", pc_now, e_err, o_cmt_nocmt);
        end
        // data only means something with a write
        if (e_wen && o_cmt_data !== e_data) begin
          report_mismatch(cat, "o_cmt_data", pc_now, e_data, o_cmt_data);
        end
        model_pc = e_npc;
        commit_cnt++;
        if (model_pc == PROG_END) begin
          run_done = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d commits", cycle_cnt, commit_cnt);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main_flow
    int total_checks;
    int total_errs;
    i_rst_n            = 1'b0;
    i_if_axi_ready     = 1'b0;
    i_if_axi_data_read = '0;
    i_if_axi_resp      = '0;
    rng                = 32'd17125;
    model_pc           = BASE;
    run_done           = 1'b0;
    first_req          = 1'b1;
    commit_cnt         = 0;
    total_checks       = 0;
    total_errs         = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int t = 0; t < 6; t++) begin
      test_checks[t] = 0;
      test_errs[t]   = 0;
    end
    build_program();
    // outputs quiet while reset is held
    repeat (4) begin
      @(posedge clk);
      #1;
      test_checks[0]++;
      if (o_if_axi_valid !== 1'b0) begin
        note_failure(0, "o_if_axi_valid high during reset");
      end
      if (o_cmt_valid !== 1'b0) begin
        note_failure(0, "o_cmt_valid high during reset");
      end
    end
    #1;
    i_rst_n = 1'b1;
    while (first_req) begin
      @(posedge clk);
    end
    $display("test %0s: checks %0d errors %0d", test_name(0), test_checks[0], test_errs[0]);
    while (!run_done) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    for (int t = 1; t < 6; t++) begin
      $display("test %0s: checks %0d errors %0d", test_name(t), test_checks[t], test_errs[t]);
    end
    for (int t = 0; t < 6; t++) begin
      total_checks += test_checks[t];
      total_errs   += test_errs[t];
    end
    $display("commits %0d, checks %0d, errors %0d", commit_cnt, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/rv_core_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/exe_stage.sv
hdl/wb_stage.sv
hdl/rv_core_top.sv
testbench/tb_rv_core.sv
